// ==== project.f ====
cpu_pkg.sv
issue_stage.sv
control_decoder.sv
register_file.sv
id_ex_register.sv
execute_stage.sv
memory_stage.sv
pipe_core.sv
tb_pipe_core.sv

// ==== Bender.yml ====
package:
  name: pipe_core

sources:
  - cpu_pkg.sv
  - issue_stage.sv
  - control_decoder.sv
  - register_file.sv
  - id_ex_register.sv
  - execute_stage.sv
  - memory_stage.sv
  - pipe_core.sv
  - target: simulation
    files:
      - tb_pipe_core.sv

// ==== tb_pipe_core.sv ====
`timescale 1ns/1ps

module tb_pipe_core import cpu_pkg::*; ();

  logic       clk;
  logic       reset;
  logic       inst_valid;
  inst_word_u inst;
  logic       inst_ready;
  wb_t        wb;

  logic [data_width-1:0]     model_regs [2**reg_addr_width];
  logic [data_width-1:0]     model_mem [dmem_words];
  wb_t                       exp_q [$];  // expected write-backs in program order
  int                        exp_count;
  logic [reg_addr_width-1:0] exp_dest;
  logic [data_width-1:0]     exp_data;
  logic                      started;

  pipe_core u_pipe_core (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .inst_ready (inst_ready),
    .wb         (wb)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on first failure");
  endtask

  function automatic void refresh_head();
    exp_count = exp_q.size();
    if (exp_count > 0) begin
      exp_dest = exp_q[0].dest;
      exp_data = exp_q[0].data;
    end
  endfunction

  // ====================
  // checks
  // ====================
  a_idle_after_reset: assert property (
    @(posedge clk) disable iff (reset) !started |-> !wb.valid && inst_ready
  ) else stop_on_failure("write-back or back-pressure before the first instruction");

  a_wb_expected: assert property (
    @(posedge clk) disable iff (reset) wb.valid |-> exp_count > 0
  ) else stop_on_failure("write-back arrived when none was expected");

  a_wb_value: assert property (
    @(posedge clk) disable iff (reset)
    wb.valid && exp_count > 0 |-> wb.dest == exp_dest && wb.data == exp_data
  ) else stop_on_failure($sformatf("error at %0t: write-back r%0d=%h, expected r%0d=%h",
                                   $time, $sampled(wb.dest), $sampled(wb.data),
                                   $sampled(exp_dest), $sampled(exp_data)));

  a_stall_one_cycle: assert property (
    @(posedge clk) disable iff (reset) !inst_ready |=> inst_ready
  ) else stop_on_failure("inst_ready stayed low for more than one cycle");

  // retire the head once its write-back has been checked
  always @(posedge clk) begin
    if (!reset && wb.valid && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      refresh_head();
    end
  end

  // ====================
  // reference model
  // ====================
  function automatic void run_model(input inst_word_u w);
    logic [data_width-1:0]     a;
    logic [data_width-1:0]     b;
    logic [data_width-1:0]     sext;
    logic [data_width-1:0]     addr;
    logic [data_width-1:0]     res;
    logic [reg_addr_width-1:0] dst;
    logic                      wr;
    wb_t                       entry;
    a    = model_regs[w.r_fmt.rs];
    b    = model_regs[w.r_fmt.rt];
    sext = {{16{w.i_fmt.imm[15]}}, w.i_fmt.imm};
    addr = a + sext;
    dst  = w.i_fmt.rt;
    res  = '0;
    wr   = 1'b0;
    case (w.i_fmt.opcode)
      op_rtype: begin
        dst = w.r_fmt.rd;
        wr  = 1'b1;
        case (w.r_fmt.funct)
          fn_add:  res = a + b;
          fn_sub:  res = a - b;
          fn_and:  res = a & b;
          fn_or:   res = a | b;
          fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: wr = 1'b0;  // shifts and the rest are no-ops
        endcase
      end
      op_addi: begin
        res = addr;
        wr  = 1'b1;
      end
      op_lw: begin
        res = model_mem[addr[7:2]];
        wr  = 1'b1;
      end
      op_sw: model_mem[addr[7:2]] = b;
      default: wr = 1'b0;
    endcase
    if (wr && dst != '0) begin
      model_regs[dst] = res;
      entry.valid = 1'b1;
      entry.dest  = dst;
      entry.data  = res;
      exp_q.push_back(entry);
      refresh_head();
    end
  endfunction

  // ====================
  // stimulus
  // ====================
  function automatic inst_word_u make_r(input logic [5:0] funct, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [4:0] rd);
    inst_word_u w;
    w = '0;
    w.r_fmt.opcode = op_rtype;
    w.r_fmt.rs     = rs;
    w.r_fmt.rt     = rt;
    w.r_fmt.rd     = rd;
    w.r_fmt.funct  = funct;
    return w;
  endfunction

  function automatic inst_word_u make_i(input logic [5:0] opcode, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    inst_word_u w;
    w.i_fmt.opcode = opcode;
    w.i_fmt.rs     = rs;
    w.i_fmt.rt     = rt;
    w.i_fmt.imm    = imm;
    return w;
  endfunction

  function automatic logic [4:0] small_reg();
    return 5'($urandom % 8);  // few registers, so dependencies are frequent
  endfunction

  function automatic logic [5:0] random_funct();
    logic [5:0] fn;
    case ($urandom % 5)
      0:       fn = fn_add;
      1:       fn = fn_sub;
      2:       fn = fn_and;
      3:       fn = fn_or;
      default: fn = fn_slt;
    endcase
    return fn;
  endfunction

  task automatic idle(input int cycles);
    repeat (cycles) @(posedge clk);
    #2;
  endtask

  // offer one word, count cycles spent with inst_ready low
  task automatic offer(input inst_word_u word, output int waits);
    waits      = 0;
    started    = 1'b1;
    inst       = word;
    inst_valid = 1'b1;
    @(negedge clk);
    while (!inst_ready) begin
      if (waits >= 10) stop_on_failure("timed out waiting for inst_ready");
      waits++;
      @(negedge clk);
    end
    @(posedge clk);  // accept edge
    run_model(word);
    #2;
    inst_valid = 1'b0;
  endtask

  task automatic random_mix(input int count);
    inst_word_u w;
    int         waits;
    for (int n = 0; n < count; n++) begin
      case ($urandom % 8)
        0, 1, 2, 3: w = make_r(random_funct(), small_reg(), small_reg(), small_reg());
        4:          w = make_i(op_addi, small_reg(), small_reg(), 16'($urandom));
        5:          w = make_i(op_sw, 5'd0, small_reg(), 16'(($urandom % 16) * 4));
        6:          w = make_i(op_lw, 5'd0, small_reg(), 16'(($urandom % 16) * 4));
        default:    w = make_i(6'h3f, small_reg(), small_reg(), 16'($urandom));
      endcase
      offer(w, waits);
    end
  endtask

  initial begin
    inst_word_u w;
    int         waits;
    int         guard;
    guard      = $urandom(80);  // seed
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    started    = 1'b0;
    exp_count  = 0;
    exp_dest   = '0;
    exp_data   = '0;
    for (int i = 0; i < 2**reg_addr_width; i++) model_regs[i] = '0;
    for (int i = 0; i < dmem_words; i++) model_mem[i] = '0;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    idle(3);

    for (int r = 1; r < 8; r++) begin
      offer(make_i(op_addi, 5'd0, 5'(r), 16'($urandom)), waits);
    end
    offer(make_i(op_addi, 5'd1, 5'd0, 16'h0005), waits);  // r0 target, no write-back
    offer(make_i(op_addi, 5'd2, 5'd8, 16'hfff0), waits);

    offer(make_r(fn_add, 5'd1, 5'd2, 5'd9), waits);
    offer(make_r(fn_sub, 5'd9, 5'd3, 5'd10), waits);  // one before
    offer(make_r(fn_slt, 5'd4, 5'd9, 5'd11), waits);  // two before

    offer(make_i(op_sw, 5'd0, 5'd5, 16'd32), waits);
    offer(make_i(op_addi, 5'd6, 5'd6, 16'd1), waits);
    offer(make_i(op_lw, 5'd0, 5'd12, 16'd32), waits);

    // load-use pair followed by one more word
    idle(2);
    offer(make_i(op_lw, 5'd0, 5'd13, 16'd32), waits);
    offer(make_r(fn_add, 5'd13, 5'd1, 5'd14), waits);
    assert (waits == 0)
      else stop_on_failure($sformatf("error at %0t: load-use word waited %0d cycles",
                                     $time, waits));
    offer(make_r(fn_or, 5'd14, 5'd13, 5'd15), waits);
    assert (waits == 1)
      else stop_on_failure($sformatf("error at %0t: stall lasted %0d cycles, expected 1",
                                     $time, waits));

    offer(make_i(6'h3f, 5'd1, 5'd2, 16'h1234), waits);
    w = make_r(6'h00, 5'd1, 5'd2, 5'd3);  // sll, not supported
    w.r_fmt.shamt = 5'd4;
    offer(w, waits);
    offer(make_r(6'h27, 5'd1, 5'd2, 5'd4), waits);  // nor
    offer(make_r(fn_and, 5'd1, 5'd2, 5'd4), waits);

    random_mix(120);

    guard = 0;
    while (exp_q.size() != 0 && guard < 100) begin
      @(posedge clk);
      guard++;
    end
    idle(4);
    if (exp_q.size() != 0) begin
      stop_on_failure("timed out waiting for the remaining write-backs");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// ==== pipe_core.sv ====
`timescale 1ns/1ps

module pipe_core import cpu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       inst_valid,
  input  inst_word_u inst,
  output logic       inst_ready,
  output wb_t        wb
);

  logic                      stall;
  logic                      if_id_valid;
  inst_word_u                if_id_inst;
  ctrl_t                     ctrl;
  logic [reg_addr_width-1:0] dest;
  logic [data_width-1:0]     imm;
  logic [data_width-1:0]     rd_data_a;
  logic [data_width-1:0]     rd_data_b;
  id_ex_t                    id_ex;
  ex_mem_t                   ex_mem;

  issue_stage u_issue_stage (
    .clk         (clk),
    .reset       (reset),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .inst_ready  (inst_ready),
    .ex_mem_read (id_ex.ctrl.mem_read),
    .ex_dest     (id_ex.dest),
    .stall       (stall),
    .if_id_valid (if_id_valid),
    .if_id_inst  (if_id_inst)
  );

  control_decoder u_control_decoder (
    .if_id_valid (if_id_valid),
    .if_id_inst  (if_id_inst),
    .ctrl        (ctrl),
    .dest        (dest),
    .imm         (imm)
  );

  register_file u_register_file (
    .clk       (clk),
    .reset     (reset),
    .rs        (if_id_inst.r_fmt.rs),
    .rt        (if_id_inst.r_fmt.rt),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wb        (wb)
  );

  id_ex_register u_id_ex_register (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .ctrl       (ctrl),
    .dest       (dest),
    .imm        (imm),
    .if_id_inst (if_id_inst),
    .rd_data_a  (rd_data_a),
    .rd_data_b  (rd_data_b),
    .id_ex      (id_ex)
  );

  execute_stage u_execute_stage (
    .clk    (clk),
    .reset  (reset),
    .id_ex  (id_ex),
    .wb     (wb),
    .ex_mem (ex_mem)
  );

  memory_stage u_memory_stage (
    .clk    (clk),
    .reset  (reset),
    .ex_mem (ex_mem),
    .wb     (wb)
  );

endmodule

// ==== memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage import cpu_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  ex_mem_t ex_mem,
  output wb_t     wb
);

  logic [data_width-1:0]         ram [dmem_words];
  logic [$clog2(dmem_words)-1:0] word_idx;
  logic [data_width-1:0]         rd_word;

  assign word_idx = ex_mem.alu_result[2 +: $clog2(dmem_words)];  // word aligned
  assign rd_word  = ram[word_idx];

  // ====================
  // data RAM
  // ====================
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < dmem_words; i++) begin
        ram[i] <= '0;
      end
    end else if (ex_mem.mem_write) begin
      ram[word_idx] <= ex_mem.store_data;
    end
  end

  // ====================
  // MEM/WB register
  // ====================
  always_ff @(posedge clk) begin
    wb.dest <= ex_mem.dest;
    wb.data <= ex_mem.mem_read ? rd_word : ex_mem.alu_result;
    if (reset) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= ex_mem.reg_write && (ex_mem.dest != '0);  // r0 writes vanish here
    end
  end

  a_rd_wr_excl: assert property (
    @(posedge clk) disable iff (reset) !(ex_mem.mem_read && ex_mem.mem_write)
  ) else $error("load and store in the same slot");

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  id_ex_t  id_ex,
  input  wb_t     wb,
  output ex_mem_t ex_mem
);

  logic [data_width-1:0] opnd_a;
  logic [data_width-1:0] fwd_b;
  logic [data_width-1:0] opnd_b;
  logic [data_width-1:0] alu_out;

  // ====================
  // forwarding
  // ====================
  // nearest producer wins
  function automatic logic [data_width-1:0] forward(
    input logic [reg_addr_width-1:0] src,
    input logic [data_width-1:0]     reg_val
  );
    logic [data_width-1:0] val;
    if (src != '0 && ex_mem.reg_write && ex_mem.dest == src) begin
      val = ex_mem.alu_result;
    end else if (src != '0 && wb.valid && wb.dest == src) begin
      val = wb.data;
    end else begin
      val = reg_val;
    end
    return val;
  endfunction

  always_comb begin
    opnd_a = forward(id_ex.rs, id_ex.op_a);
    fwd_b  = forward(id_ex.rt, id_ex.op_b);
  end

  assign opnd_b = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b;

  // ====================
  // ALU
  // ====================
  always_comb begin
    case (id_ex.ctrl.alu_op)
      alu_add: alu_out = opnd_a + opnd_b;
      alu_sub: alu_out = opnd_a - opnd_b;
      alu_and: alu_out = opnd_a & opnd_b;
      alu_or:  alu_out = opnd_a | opnd_b;
      alu_slt: alu_out = {{(data_width-1){1'b0}}, $signed(opnd_a) < $signed(opnd_b)};
      default: alu_out = '0;
    endcase
  end

  // ====================
  // EX/MEM register
  // ====================
  always_ff @(posedge clk) begin
    ex_mem.dest       <= id_ex.dest;
    ex_mem.alu_result <= alu_out;
    ex_mem.store_data <= fwd_b;  // sw data comes from rt
    if (reset) begin
      ex_mem.mem_read  <= 1'b0;
      ex_mem.mem_write <= 1'b0;
      ex_mem.reg_write <= 1'b0;
    end else begin
      ex_mem.mem_read  <= id_ex.ctrl.mem_read;
      ex_mem.mem_write <= id_ex.ctrl.mem_write;
      ex_mem.reg_write <= id_ex.ctrl.reg_write;
    end
  end

endmodule

// ==== id_ex_register.sv ====
`timescale 1ns/1ps

module id_ex_register import cpu_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      stall,
  input  ctrl_t                     ctrl,
  input  logic [reg_addr_width-1:0] dest,
  input  logic [data_width-1:0]     imm,
  input  inst_word_u                if_id_inst,
  input  logic [data_width-1:0]     rd_data_a,
  input  logic [data_width-1:0]     rd_data_b,
  output id_ex_t                    id_ex
);

  // ====================
  // ID/EX register
  // ====================
  always_ff @(posedge clk) begin
    if (reset || stall) begin
      id_ex <= '0;  // bubble
    end else begin
      id_ex.ctrl <= ctrl;
      id_ex.rs   <= if_id_inst.r_fmt.rs;
      id_ex.rt   <= if_id_inst.r_fmt.rt;
      id_ex.dest <= dest;
      id_ex.op_a <= rd_data_a;
      id_ex.op_b <= rd_data_b;
      id_ex.imm  <= imm;
    end
  end

  // the held instruction must not also leave a copy behind the bubble
  a_bubble_no_write: assert property (
    @(posedge clk) disable iff (reset)
    stall |=> !id_ex.ctrl.reg_write && !id_ex.ctrl.mem_write
  ) else $error("stall bubble carries a write");

endmodule

// ==== register_file.sv ====
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [reg_addr_width-1:0] rs,
  input  logic [reg_addr_width-1:0] rt,
  output logic [data_width-1:0]     rd_data_a,
  output logic [data_width-1:0]     rd_data_b,
  input  wb_t                       wb
);

  logic [data_width-1:0] regs [2**reg_addr_width];

  // write-first: same-cycle write-back is visible to ID
  function automatic logic [data_width-1:0] read_port(input logic [reg_addr_width-1:0] idx);
    logic [data_width-1:0] val;
    if (idx == '0) begin
      val = '0;
    end else if (wb.valid && wb.dest == idx) begin
      val = wb.data;
    end else begin
      val = regs[idx];
    end
    return val;
  endfunction

  always_comb begin
    rd_data_a = read_port(rs);
    rd_data_b = read_port(rt);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**reg_addr_width; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.dest != '0) begin
      regs[wb.dest] <= wb.data;
    end
  end

  a_zero_reg_const: assert property (@(posedge clk) disable iff (reset) $stable(regs[0]))
    else $error("register zero storage changed");

endmodule

// ==== control_decoder.sv ====
`timescale 1ns/1ps

module control_decoder import cpu_pkg::*; (
  input  logic                      if_id_valid,
  input  inst_word_u                if_id_inst,
  output ctrl_t                     ctrl,
  output logic [reg_addr_width-1:0] dest,
  output logic [data_width-1:0]     imm
);

  logic [imm_width-1:0] raw_imm;

  assign raw_imm = if_id_inst.i_fmt.imm;
  assign imm     = {{(data_width-imm_width){raw_imm[imm_width-1]}}, raw_imm};

  always_comb begin
    ctrl = '0;  // no-op unless decoded below
    if (if_id_valid) begin
      case (if_id_inst.i_fmt.opcode)
        op_rtype: begin
          ctrl.reg_write = 1'b1;
          ctrl.reg_dst   = 1'b1;
          case (if_id_inst.r_fmt.funct)
            fn_add:  ctrl.alu_op = alu_add;
            fn_sub:  ctrl.alu_op = alu_sub;
            fn_and:  ctrl.alu_op = alu_and;
            fn_or:   ctrl.alu_op = alu_or;
            fn_slt:  ctrl.alu_op = alu_slt;
            default: ctrl = '0;  // unknown funct retires silently
          endcase
        end
        op_addi: begin
          ctrl.alu_src   = 1'b1;
          ctrl.reg_write = 1'b1;
        end
        op_lw: begin
          ctrl.alu_src   = 1'b1;
          ctrl.mem_read  = 1'b1;
          ctrl.reg_write = 1'b1;
        end
        op_sw: begin
          ctrl.alu_src   = 1'b1;
          ctrl.mem_write = 1'b1;
        end
        default: ctrl = '0;
      endcase
    end
  end

  assign dest = ctrl.reg_dst ? if_id_inst.r_fmt.rd : if_id_inst.i_fmt.rt;

endmodule

// ==== issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage import cpu_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      inst_valid,
  input  inst_word_u                inst,
  output logic                      inst_ready,
  input  logic                      ex_mem_read,
  input  logic [reg_addr_width-1:0] ex_dest,
  output logic                      stall,
  output logic                      if_id_valid,
  output inst_word_u                if_id_inst
);

  logic src_hit;
  logic accept;

  // load in ID/EX feeding the held instruction
  assign src_hit = (ex_dest == if_id_inst.r_fmt.rs) || (ex_dest == if_id_inst.r_fmt.rt);
  assign stall   = if_id_valid && ex_mem_read && (ex_dest != '0) && src_hit;

  assign inst_ready = !stall;
  assign accept     = inst_valid && inst_ready;

  // ====================
  // IF/ID register
  // ====================
  always_ff @(posedge clk) begin
    if (reset) begin
      if_id_valid <= 1'b0;
    end else if (!stall) begin
      if_id_valid <= accept;  // empties when nothing is offered
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      if_id_inst <= inst;
    end
  end

endmodule

// ==== cpu_pkg.sv ====
package cpu_pkg;

  // ====================
  // widths
  // ====================
  localparam int data_width     = 32;
  localparam int reg_addr_width = 5;
  localparam int imm_width      = 16;
  localparam int dmem_words     = 64;

  // ====================
  // encodings
  // ====================
  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_addi  = 6'h08;
  localparam logic [5:0] op_lw    = 6'h23;
  localparam logic [5:0] op_sw    = 6'h2b;

  localparam logic [5:0] fn_add = 6'h20;
  localparam logic [5:0] fn_sub = 6'h22;
  localparam logic [5:0] fn_and = 6'h24;
  localparam logic [5:0] fn_or  = 6'h25;
  localparam logic [5:0] fn_slt = 6'h2a;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt
  } alu_op_e;

  typedef struct packed {
    logic [5:0]                opcode;
    logic [reg_addr_width-1:0] rs;
    logic [reg_addr_width-1:0] rt;
    logic [reg_addr_width-1:0] rd;
    logic [4:0]                shamt;  // no shifts in this core
    logic [5:0]                funct;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]                opcode;
    logic [reg_addr_width-1:0] rs;
    logic [reg_addr_width-1:0] rt;
    logic [imm_width-1:0]      imm;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } inst_word_u;

  // ====================
  // stage records
  // ====================
  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src;    // immediate as operand b
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
    logic    reg_dst;    // rd instead of rt
  } ctrl_t;

  typedef struct packed {
    ctrl_t                     ctrl;
    logic [reg_addr_width-1:0] rs;
    logic [reg_addr_width-1:0] rt;
    logic [reg_addr_width-1:0] dest;
    logic [data_width-1:0]     op_a;
    logic [data_width-1:0]     op_b;
    logic [data_width-1:0]     imm;
  } id_ex_t;

  typedef struct packed {
    logic                      mem_read;
    logic                      mem_write;
    logic                      reg_write;
    logic [reg_addr_width-1:0] dest;
    logic [data_width-1:0]     alu_result;
    logic [data_width-1:0]     store_data;
  } ex_mem_t;

  typedef struct packed {
    logic                      valid;
    logic [reg_addr_width-1:0] dest;
    logic [data_width-1:0]     data;
  } wb_t;

endpackage
